/* design/wb_axil_pkg.sv */
package wb_axil_pkg;

    // AXI4-Lite data bus
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int AXIL_STRB_W = DATA_W / BYTE_W;

    // Index of a byte lane inside one word
    localparam int LANE_IDX_W = $clog2(AXIL_STRB_W);

    localparam logic [AXIL_STRB_W-1:0] STRB_FULL = '1;

    typedef logic [1:0] axil_resp_t;

    // Write response codes
    localparam axil_resp_t RESP_OKAY = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

/* design/wb_layer_pkg.sv */
package wb_layer_pkg;

    import wb_axil_pkg::*;

    typedef enum logic [3:0] {
        LAYER_CONV = 4'd0,
        LAYER_DENSE = 4'd1
    } layer_kind_t;

    // Job record is sized for the widest supported configuration
    localparam int JOB_ADDR_W = 32;
    localparam int JOB_MAX_CH = 8;

    // Byte steps between channels
    localparam int PSUM_STEP = 4;
    localparam int DENSE_OUT_STEP = 1;

    typedef struct packed {
        layer_kind_t layer;
        logic is_final;
        logic [JOB_ADDR_W-1:0] base;
        logic [JOB_MAX_CH-1:0][DATA_W-1:0] data;
    } wb_job_t;

endpackage

/* design/wb_pipe_reg.sv */
module wb_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     i_valid,
    input  payload_t i_data,
    output logic     o_ready,
    output logic     o_valid,
    output payload_t o_data,
    input  logic     i_ready_dn
);

    logic load;

    // Free slot, or the held item leaves this cycle
    assign o_ready = !o_valid || i_ready_dn;
    assign load = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        o_valid && !i_ready_dn |=> o_valid && $stable(o_data)
    );

endmodule

/* design/wb_addr_gen.sv */
module wb_addr_gen #(
    parameter int ADDR_W = 32,
    parameter int N_CH = 3
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 i_job_valid,
    input  wb_layer_pkg::wb_job_t                i_job,
    input  logic [ADDR_W-1:0]                    i_plane_size,
    output logic                                 o_job_ready,
    output logic                                 o_beat_valid,
    output logic [ADDR_W-1:0]                    o_beat_addr,
    output logic [wb_axil_pkg::DATA_W-1:0]       o_beat_data,
    output logic [wb_axil_pkg::AXIL_STRB_W-1:0]  o_beat_strb,
    input  logic                                 i_beat_ready
);

    import wb_layer_pkg::*;
    import wb_axil_pkg::*;

    localparam int CH_W = $clog2(N_CH + 1);

    logic                        busy_q;
    logic [CH_W-1:0]             ch_q;
    logic [ADDR_W-1:0]           addr_q;
    logic [ADDR_W-1:0]           stride_q;
    logic [ADDR_W-1:0]           stride_d;
    logic                        final_q;
    logic [N_CH-1:0][DATA_W-1:0] data_q;
    logic [DATA_W-1:0]           ch_val;
    logic [LANE_IDX_W-1:0]       lane;
    logic                        take_job;
    logic                        beat_done;
    logic                        last_beat;

    assign o_job_ready = !busy_q;
    assign take_job = i_job_valid && o_job_ready;
    assign beat_done = o_beat_valid && i_beat_ready;
    assign last_beat = ch_q == CH_W'(N_CH - 1);

    // Channel stride by layer kind and write form
    always_comb begin
        case (i_job.layer)
            LAYER_DENSE: begin
                stride_d = i_job.is_final ? ADDR_W'(DENSE_OUT_STEP) : ADDR_W'(PSUM_STEP);
            end
            default: begin
                // Partial sums count the convolution plane in words
                stride_d = i_job.is_final ? i_plane_size : i_plane_size * ADDR_W'(PSUM_STEP);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            ch_q <= '0;
        end else if (take_job) begin
            busy_q <= 1'b1;
            ch_q <= '0;
        end else if (beat_done) begin
            busy_q <= !last_beat;
            ch_q <= last_beat ? '0 : ch_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take_job) begin
            addr_q <= i_job.base[ADDR_W-1:0];
            stride_q <= stride_d;
            final_q <= i_job.is_final;
            data_q <= i_job.data[N_CH-1:0];
        end else if (beat_done) begin
            addr_q <= addr_q + stride_q;
        end
    end

    assign o_beat_valid = busy_q;
    assign o_beat_addr = addr_q;
    assign ch_val = data_q[ch_q];
    assign lane = addr_q[LANE_IDX_W-1:0];

    // Final outputs go out as one byte in its lane
    always_comb begin
        if (final_q) begin
            o_beat_strb = AXIL_STRB_W'(1) << lane;
            o_beat_data = DATA_W'(ch_val[BYTE_W-1:0]) << (lane * BYTE_W);
        end else begin
            o_beat_strb = STRB_FULL;
            o_beat_data = ch_val;
        end
    end

    a_ch_range: assert property (
        @(posedge clk) disable iff (!resetn)
        o_beat_valid |-> ch_q < CH_W'(N_CH)
    );

endmodule

/* design/wb_axil_writer.sv */
module wb_axil_writer #(
    parameter int ADDR_W = 32
) (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 i_beat_valid,
    input  logic [ADDR_W-1:0]                    i_beat_addr,
    input  logic [wb_axil_pkg::DATA_W-1:0]       i_beat_data,
    input  logic [wb_axil_pkg::AXIL_STRB_W-1:0]  i_beat_strb,
    output logic                                 o_beat_ready,
    output logic                                 o_awvalid,
    output logic [ADDR_W-1:0]                    o_awaddr,
    input  logic                                 i_awready,
    output logic                                 o_wvalid,
    output logic [wb_axil_pkg::DATA_W-1:0]       o_wdata,
    output logic [wb_axil_pkg::AXIL_STRB_W-1:0]  o_wstrb,
    input  logic                                 i_wready,
    input  logic                                 i_bvalid,
    input  wb_axil_pkg::axil_resp_t              i_bresp,
    output logic                                 o_bready,
    output logic                                 o_wb_err
);

    import wb_axil_pkg::*;

    logic aw_q;
    logic w_q;
    logic b_q;
    logic aw_left;
    logic w_left;
    logic take_beat;

    assign o_beat_ready = !(aw_q || w_q || b_q);
    assign take_beat = i_beat_valid && o_beat_ready;

    assign o_awvalid = aw_q;
    assign o_wvalid = w_q;
    assign o_bready = b_q;

    // Channels still open after this cycle
    assign aw_left = aw_q && !i_awready;
    assign w_left = w_q && !i_wready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_q <= 1'b0;
            w_q <= 1'b0;
            b_q <= 1'b0;
            o_wb_err <= 1'b0;
        end else if (take_beat) begin
            aw_q <= 1'b1;
            w_q <= 1'b1;
        end else if (b_q) begin
            if (i_bvalid) begin
                b_q <= 1'b0;
                // Sticky until reset
                if (i_bresp != RESP_OKAY) begin
                    o_wb_err <= 1'b1;
                end
            end
        end else if (aw_q || w_q) begin
            aw_q <= aw_left;
            w_q <= w_left;
            b_q <= !aw_left && !w_left;
        end
    end

    always_ff @(posedge clk) begin
        if (take_beat) begin
            o_awaddr <= i_beat_addr;
            o_wdata <= i_beat_data;
            o_wstrb <= i_beat_strb;
        end
    end

    a_aw_hold: assert property (
        @(posedge clk) disable iff (!resetn)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr)
    );

    a_w_hold: assert property (
        @(posedge clk) disable iff (!resetn)
        o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata) && $stable(o_wstrb)
    );

endmodule

/* design/wb_top.sv */
module wb_top #(
    parameter int ADDR_W = 32,
    parameter int N_CH = 3
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  i_job_valid,
    output logic                                  o_job_ready,
    input  wb_layer_pkg::layer_kind_t             i_job_layer,
    input  logic                                  i_job_final,
    input  logic [ADDR_W-1:0]                     i_job_base,
    input  logic [N_CH-1:0][wb_axil_pkg::DATA_W-1:0] i_job_data,
    input  logic [ADDR_W-1:0]                     i_plane_size,
    output logic                                  o_awvalid,
    output logic [ADDR_W-1:0]                     o_awaddr,
    input  logic                                  i_awready,
    output logic                                  o_wvalid,
    output logic [wb_axil_pkg::DATA_W-1:0]        o_wdata,
    output logic [wb_axil_pkg::AXIL_STRB_W-1:0]   o_wstrb,
    input  logic                                  i_wready,
    input  logic                                  i_bvalid,
    input  wb_axil_pkg::axil_resp_t               i_bresp,
    output logic                                  o_bready,
    output logic                                  o_wb_err
);

    import wb_layer_pkg::*;
    import wb_axil_pkg::*;

    wb_job_t                job_in;
    wb_job_t                pipe_job;
    logic                   pipe_valid;
    logic                   pipe_ready;
    logic                   beat_valid;
    logic                   beat_ready;
    logic [ADDR_W-1:0]      beat_addr;
    logic [DATA_W-1:0]      beat_data;
    logic [AXIL_STRB_W-1:0] beat_strb;

    if (N_CH > JOB_MAX_CH || ADDR_W > JOB_ADDR_W) begin : g_cfg_check
        $error("wb_top: N_CH or ADDR_W exceeds the job record");
    end

    // Unused channel slots stay zero
    always_comb begin
        job_in = '0;
        job_in.layer = i_job_layer;
        job_in.is_final = i_job_final;
        job_in.base = JOB_ADDR_W'(i_job_base);
        job_in.data[N_CH-1:0] = i_job_data;
    end

    wb_pipe_reg #(
        .payload_t(wb_job_t)
    ) u_intake (
        .clk(clk),
        .resetn(resetn),
        .i_valid(i_job_valid),
        .i_data(job_in),
        .o_ready(o_job_ready),
        .o_valid(pipe_valid),
        .o_data(pipe_job),
        .i_ready_dn(pipe_ready)
    );

    wb_addr_gen #(
        .ADDR_W(ADDR_W),
        .N_CH(N_CH)
    ) u_addr_gen (
        .clk(clk),
        .resetn(resetn),
        .i_job_valid(pipe_valid),
        .i_job(pipe_job),
        .i_plane_size(i_plane_size),
        .o_job_ready(pipe_ready),
        .o_beat_valid(beat_valid),
        .o_beat_addr(beat_addr),
        .o_beat_data(beat_data),
        .o_beat_strb(beat_strb),
        .i_beat_ready(beat_ready)
    );

    wb_axil_writer #(
        .ADDR_W(ADDR_W)
    ) u_writer (
        .clk(clk),
        .resetn(resetn),
        .i_beat_valid(beat_valid),
        .i_beat_addr(beat_addr),
        .i_beat_data(beat_data),
        .i_beat_strb(beat_strb),
        .o_beat_ready(beat_ready),
        .o_awvalid(o_awvalid),
        .o_awaddr(o_awaddr),
        .i_awready(i_awready),
        .o_wvalid(o_wvalid),
        .o_wdata(o_wdata),
        .o_wstrb(o_wstrb),
        .i_wready(i_wready),
        .i_bvalid(i_bvalid),
        .i_bresp(i_bresp),
        .o_bready(o_bready),
        .o_wb_err(o_wb_err)
    );

endmodule

/* tests/wb_tb.sv */
module wb_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import wb_layer_pkg::*;
    import wb_axil_pkg::*;

    localparam int ADDR_W = 32;
    localparam int N_CH = 3;
    localparam int N_ROWS = 10;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT = N_ROWS * N_CH * 20 + RESET_CYCLES;

    typedef struct {
        layer_kind_t           layer;
        logic                  is_final;
        logic [ADDR_W-1:0]     base;
        logic [ADDR_W-1:0]     plane;
        logic [N_CH-1:0][31:0] data;
        axil_resp_t            resp;
    } job_row_t;

    typedef struct {
        logic [ADDR_W-1:0] addr;
        logic [31:0]       data;
        logic [3:0]        strb;
        axil_resp_t        resp;
    } write_t;

    logic clk = 1'b0;
    logic resetn;
    logic i_job_valid;
    logic o_job_ready;
    layer_kind_t i_job_layer;
    logic i_job_final;
    logic [ADDR_W-1:0] i_job_base;
    logic [N_CH-1:0][31:0] i_job_data;
    logic [ADDR_W-1:0] i_plane_size;
    logic o_awvalid;
    logic [ADDR_W-1:0] o_awaddr;
    logic i_awready;
    logic o_wvalid;
    logic [31:0] o_wdata;
    logic [3:0] o_wstrb;
    logic i_wready;
    logic i_bvalid;
    axil_resp_t i_bresp;
    logic o_bready;
    logic o_wb_err;

    job_row_t rows[N_ROWS];
    write_t exp_q[$];
    integer seed;
    int cycle_cnt = 0;
    logic err_exp = 1'b0;

    wb_top #(.ADDR_W(ADDR_W), .N_CH(N_CH)) dut0 (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: writes still pending after %0d cycles", cycle_cnt);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_row(input int idx, input layer_kind_t layer, input logic fin,
                           input logic [31:0] base, input logic [31:0] plane,
                           input logic [N_CH-1:0][31:0] data, input axil_resp_t resp);
        rows[idx] = '{layer, fin, base, plane, data, resp};
    endtask

    // Expected beats straight from the address and lane rules
    function automatic void queue_expected(input job_row_t row);
        write_t w;
        logic [ADDR_W-1:0] step;
        for (int k = 0; k < N_CH; k++) begin
            if (row.layer == LAYER_CONV) begin
                step = row.is_final ? row.plane : row.plane * PSUM_STEP;
            end else begin
                step = row.is_final ? 1 : PSUM_STEP;
            end
            w.addr = row.base + k * step;
            w.resp = row.resp;
            if (row.is_final) begin
                w.strb = 4'b0001 << w.addr[1:0];
                w.data = {24'd0, row.data[k][7:0]} << (8 * w.addr[1:0]);
            end else begin
                w.strb = STRB_FULL;
                w.data = row.data[k];
            end
            exp_q.push_back(w);
        end
    endfunction

    task automatic offer_job(input job_row_t row);
        // Plane size may only change with the pipe drained
        if (row.plane !== i_plane_size) begin
            i_job_valid = 1'b0;
            while (exp_q.size() != 0) @(negedge clk);
            i_plane_size = row.plane;
        end
        i_job_valid = 1'b1;
        i_job_layer = row.layer;
        i_job_final = row.is_final;
        i_job_base = row.base;
        i_job_data = row.data;
        while (!o_job_ready) @(negedge clk);
        queue_expected(row);
        @(negedge clk);
    endtask

    task automatic serve_write();
        write_t exp;
        logic [ADDR_W-1:0] got_addr;
        logic [31:0] got_data;
        logic [3:0] got_strb;
        int aw_wait;
        int w_wait;
        bit aw_done;
        bit w_done;
        aw_wait = $random(seed) & 3;
        w_wait = $random(seed) & 3;
        aw_done = 0;
        w_done = 0;
        while (!(aw_done && w_done)) begin
            i_awready = 1'b0;
            i_wready = 1'b0;
            if (!aw_done && o_awvalid) begin
                if (aw_wait == 0) begin
                    i_awready = 1'b1;
                    got_addr = o_awaddr;
                    aw_done = 1;
                end else begin
                    aw_wait--;
                end
            end
            if (!w_done && o_wvalid) begin
                if (w_wait == 0) begin
                    i_wready = 1'b1;
                    got_data = o_wdata;
                    got_strb = o_wstrb;
                    w_done = 1;
                end else begin
                    w_wait--;
                end
            end
            @(negedge clk);
        end
        i_awready = 1'b0;
        i_wready = 1'b0;
        if (exp_q.size() == 0) begin
            $display("write to %h arrived with no job pending", got_addr);
            $display("ERRORS FOUND");
            $fatal(1, "unexpected write");
        end
        exp = exp_q.pop_front();
        check_value(got_addr, exp.addr, "write address");
        check_value(got_data, exp.data, "write data");
        check_value(got_strb, exp.strb, "write strobe");
        check_value(o_bready, 1'b1, "bready after both handshakes");
        if (exp.resp != RESP_OKAY) begin
            err_exp = 1'b1;
        end
        i_bvalid = 1'b1;
        i_bresp = exp.resp;
        @(negedge clk);
        i_bvalid = 1'b0;
        i_bresp = RESP_OKAY;
        check_value(o_wb_err, err_exp, "write error flag");
    endtask

    // Memory side
    initial begin
        @(posedge resetn);
        forever begin
            @(negedge clk);
            if (o_awvalid || o_wvalid) begin
                serve_write();
            end
        end
    end

    initial begin
        seed = 32'hddee_7a2a;
        resetn = 1'b0;
        i_job_valid = 1'b0;
        i_job_layer = LAYER_CONV;
        i_job_final = 1'b0;
        i_job_base = '0;
        i_job_data = '0;
        i_plane_size = '0;
        i_awready = 1'b0;
        i_wready = 1'b0;
        i_bvalid = 1'b0;
        i_bresp = RESP_OKAY;
        set_row(0, LAYER_CONV, 1, 32'h1000, 32'h41, {32'h99aabbcc, 32'h55667788, 32'h11223344},
                RESP_OKAY);
        set_row(1, LAYER_CONV, 1, 32'h2003, 32'h41, {32'h0000a5c3, 32'h0000005a, 32'h000000f1},
                RESP_OKAY);
        set_row(2, LAYER_CONV, 0, 32'h4000, 32'h41, {32'hdeadbeef, 32'h01234567, 32'h89abcdef},
                RESP_OKAY);
        set_row(3, LAYER_DENSE, 1, 32'h5002, 32'h41, {32'h00000033, 32'h00000022, 32'h00000011},
                RESP_OKAY);
        set_row(4, LAYER_DENSE, 0, 32'h6000, 32'h41, {32'hcafe0003, 32'hcafe0002, 32'hcafe0001},
                RESP_OKAY);
        set_row(5, LAYER_DENSE, 1, 32'h7001, 32'h41, {32'h000000c6, 32'h000000b5, 32'h000000a4},
                RESP_OKAY);
        set_row(6, LAYER_CONV, 0, 32'h8000, 32'h100, {32'h76543210, 32'hfedcba98, 32'h0f0f0f0f},
                RESP_OKAY);
        set_row(7, LAYER_CONV, 1, 32'h9002, 32'h100, {32'h0000007e, 32'h0000006d, 32'h0000005c},
                RESP_SLVERR);
        set_row(8, LAYER_DENSE, 0, 32'ha004, 32'h100, {32'h13579bdf, 32'h2468ace0, 32'h55aa55aa},
                RESP_OKAY);
        set_row(9, LAYER_CONV, 1, 32'hb000, 32'h100, {32'h00000003, 32'h00000002, 32'h00000001},
                RESP_OKAY);
        repeat (RESET_CYCLES) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_value(o_wb_err, 1'b0, "wb_err after reset");
        check_value(o_job_ready, 1'b1, "job ready after reset");
        check_value({o_awvalid, o_wvalid, o_bready}, 3'b000, "AXI valids after reset");
        for (int r = 0; r < N_ROWS; r++) begin
            offer_job(rows[r]);
        end
        i_job_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (10) @(negedge clk);
        check_value({o_awvalid, o_wvalid}, 2'b00, "AXI valids after drain");
        check_value(o_wb_err, 1'b1, "sticky write error flag");
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* compile.f */
design/wb_axil_pkg.sv
design/wb_layer_pkg.sv
design/wb_pipe_reg.sv
design/wb_addr_gen.sv
design/wb_axil_writer.sv
design/wb_top.sv
tests/wb_tb.sv

/* Bender.yml */
package:
  name: wb_writeback

sources:
  # Packages first, the layer package imports the AXI package
  - design/wb_axil_pkg.sv
  - design/wb_layer_pkg.sv
  - design/wb_pipe_reg.sv
  - design/wb_addr_gen.sv
  - design/wb_axil_writer.sv
  - design/wb_top.sv
  - target: simulation
    files:
      - tests/wb_tb.sv
